// File: Makefile
TOP := tb_sata_rx_monitor

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) \
		-f sata_rx_monitor.f --Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// File: rtl/sata_frame_monitor.sv
`timescale 1ns/1ps
`include "sata_mon_params.svh"

module sata_frame_monitor (
    input  logic                      gtrefclk,
    input  logic                      rst_n,
    input  sata_mon_pkg::class_beat_t cls,
    input  logic                      dword_aligned,
    output sata_mon_pkg::frame_stat_t last_stat,
    output logic                      in_frame
);

    logic [`SATA_CNT_W-1:0] data_cnt;
    logic [3:0]             prims;      // sticky {cont, hold, holda, wtrm}
    logic                   aligned_d;
    logic                   lost;
    logic                   is_sof;
    logic                   is_eof;
    logic                   is_data;
    logic [3:0]             prim_hit;

    assign is_sof  = cls.valid && (cls.kind == sata_mon_pkg::KIND_SOF);
    assign is_eof  = cls.valid && (cls.kind == sata_mon_pkg::KIND_EOF);
    assign is_data = cls.valid && (cls.kind == sata_mon_pkg::KIND_DATA);
    assign prim_hit = {4{cls.valid}} & {cls.kind == sata_mon_pkg::KIND_CONT,
                                        cls.kind == sata_mon_pkg::KIND_HOLD,
                                        cls.kind == sata_mon_pkg::KIND_HOLDA,
                                        cls.kind == sata_mon_pkg::KIND_WTRM};
    assign lost = aligned_d && !dword_aligned;  // falling edge only

    always_ff @(posedge gtrefclk) begin
        if (!rst_n) begin
            in_frame  <= 1'b0;
            data_cnt  <= '0;
            prims     <= '0;
            aligned_d <= 1'b0;
            last_stat <= '0;
        end else begin
            aligned_d <= dword_aligned;

            if (!dword_aligned || is_eof) begin
                in_frame <= 1'b0;
            end else if (is_sof) begin
                in_frame <= 1'b1;
            end

            if (!dword_aligned || is_sof) begin
                data_cnt <= '0;
                prims    <= '0;
            end else if (in_frame) begin
                if (is_data && data_cnt != {`SATA_CNT_W{1'b1}}) begin
                    data_cnt <= data_cnt + 1'b1;   // saturates
                end
                prims <= prims | prim_hit;
            end

            if (is_sof || lost) begin
                last_stat <= '{prims: prims, count: data_cnt};  // previous frame
            end
        end
    end

endmodule

// File: rtl/sata_mon_params.svh
`ifndef SATA_MON_PARAMS_SVH
`define SATA_MON_PARAMS_SVH

// stream widths
`define SATA_HW_W           16
`define SATA_DW_W           32
`define SATA_K_HW_W         2
`define SATA_K_DW_W         4

// primitives as received, K28.x lead byte in the low lane
`define SATA_PRIM_ALIGN     32'h7B4A4ABC
`define SATA_PRIM_SOF       32'h3737B57C
`define SATA_PRIM_EOF       32'hD5D5B57C
`define SATA_PRIM_CONT      32'h9999AA7C
`define SATA_PRIM_HOLD      32'hD5D5AA7C
`define SATA_PRIM_HOLDA     32'h9595AA7C
`define SATA_PRIM_WTRM      32'h5858B57C

`define SATA_CNT_W          12

// register map
`define SATA_AXI_ADDR_W     4
`define SATA_REG_STAT       4'h0
`define SATA_REG_LINK       4'h4
`define SATA_RESP_OKAY      2'b00
`define SATA_RESP_SLVERR    2'b10

`endif

// File: rtl/sata_mon_pkg.sv
`include "sata_mon_params.svh"

package sata_mon_pkg;

    typedef struct packed {
        logic [`SATA_HW_W-1:0]   data;
        logic [`SATA_K_HW_W-1:0] charisk;
    } halfword_t;

    // primitive layout, lead K character in byte 0
    typedef struct packed {
        logic [2:0][7:0] ctrl;
        logic [7:0]      kchar;
    } prim_view_t;

    typedef union packed {
        logic [`SATA_DW_W-1:0] raw;
        prim_view_t            prim;
    } dword_u;

    typedef struct packed {
        logic                    valid;
        dword_u                  word;
        logic [`SATA_K_DW_W-1:0] charisk;
    } dword_beat_t;

    typedef enum logic [3:0] {
        KIND_ALIGN,
        KIND_SOF,
        KIND_EOF,
        KIND_CONT,
        KIND_HOLD,
        KIND_HOLDA,
        KIND_WTRM,
        KIND_DATA,
        KIND_OTHER
    } prim_kind_e;

    typedef struct packed {
        logic       valid;
        prim_kind_e kind;
    } class_beat_t;

    typedef struct packed {
        logic [3:0]             prims;  // {cont, hold, holda, wtrm}
        logic [`SATA_CNT_W-1:0] count;
    } frame_stat_t;

    typedef struct packed {
        logic                        arvalid;
        logic [`SATA_AXI_ADDR_W-1:0] araddr;
    } axil_rd_req_t;

    typedef struct packed {
        logic                  rvalid;
        logic [`SATA_DW_W-1:0] rdata;
        logic [1:0]            rresp;
    } axil_rd_rsp_t;

endpackage

// File: rtl/sata_prim_decoder.sv
`timescale 1ns/1ps
`include "sata_mon_params.svh"

module sata_prim_decoder (
    input  logic                      gtrefclk,
    input  logic                      rst_n,
    input  sata_mon_pkg::dword_beat_t beat,
    output sata_mon_pkg::class_beat_t cls
);

    sata_mon_pkg::prim_kind_e kind;
    sata_mon_pkg::prim_kind_e kind_r;
    logic                     lead_k;
    logic                     cls_vld;

    // K28.5 for ALIGNp, K28.3 for the rest
    assign lead_k = (beat.word.prim.kchar == 8'hBC) || (beat.word.prim.kchar == 8'h7C);

    always_comb begin
        kind = sata_mon_pkg::KIND_OTHER;
        if (beat.charisk == 4'b0000) begin
            kind = sata_mon_pkg::KIND_DATA;
        end else if (beat.charisk == 4'b0001 && lead_k) begin
            case (beat.word.raw)
                `SATA_PRIM_ALIGN: kind = sata_mon_pkg::KIND_ALIGN;
                `SATA_PRIM_SOF:   kind = sata_mon_pkg::KIND_SOF;
                `SATA_PRIM_EOF:   kind = sata_mon_pkg::KIND_EOF;
                `SATA_PRIM_CONT:  kind = sata_mon_pkg::KIND_CONT;
                `SATA_PRIM_HOLD:  kind = sata_mon_pkg::KIND_HOLD;
                `SATA_PRIM_HOLDA: kind = sata_mon_pkg::KIND_HOLDA;
                `SATA_PRIM_WTRM:  kind = sata_mon_pkg::KIND_WTRM;
                default:          kind = sata_mon_pkg::KIND_OTHER;
            endcase
        end
    end

    always_ff @(posedge gtrefclk) begin
        if (!rst_n) begin
            cls_vld <= 1'b0;
        end else begin
            cls_vld <= beat.valid;
        end
    end

    always_ff @(posedge gtrefclk) begin
        kind_r <= kind;
    end

    assign cls = '{valid: cls_vld, kind: kind_r};

endmodule

// File: rtl/sata_rx_monitor.sv
`timescale 1ns/1ps

module sata_rx_monitor (
    input  logic                       gtrefclk,
    input  logic                       rst_n,
    input  sata_mon_pkg::halfword_t    rx_hw,
    input  logic                       link_aligned,
    input  sata_mon_pkg::axil_rd_req_t rd_req,
    output logic                       arready,
    output sata_mon_pkg::axil_rd_rsp_t rd_rsp,
    input  logic                       rready
);

    sata_mon_pkg::dword_beat_t beat;
    sata_mon_pkg::class_beat_t cls;
    sata_mon_pkg::frame_stat_t last_stat;
    logic                      dword_aligned;
    logic                      in_frame;

    sata_word_assembler i_sata_word_assembler (
        .gtrefclk      (gtrefclk),
        .rst_n         (rst_n),
        .rx_hw         (rx_hw),
        .link_aligned  (link_aligned),
        .beat          (beat),
        .dword_aligned (dword_aligned)
    );

    sata_prim_decoder i_sata_prim_decoder (
        .gtrefclk (gtrefclk),
        .rst_n    (rst_n),
        .beat     (beat),
        .cls      (cls)
    );

    sata_frame_monitor i_sata_frame_monitor (
        .gtrefclk      (gtrefclk),
        .rst_n         (rst_n),
        .cls           (cls),
        .dword_aligned (dword_aligned),
        .last_stat     (last_stat),
        .in_frame      (in_frame)
    );

    sata_stat_regs i_sata_stat_regs (
        .gtrefclk      (gtrefclk),
        .rst_n         (rst_n),
        .rd_req        (rd_req),
        .arready       (arready),
        .rd_rsp        (rd_rsp),
        .rready        (rready),
        .last_stat     (last_stat),
        .in_frame      (in_frame),
        .dword_aligned (dword_aligned)
    );

endmodule

// File: rtl/sata_stat_regs.sv
`timescale 1ns/1ps
`include "sata_mon_params.svh"

module sata_stat_regs (
    input  logic                       gtrefclk,
    input  logic                       rst_n,
    input  sata_mon_pkg::axil_rd_req_t rd_req,
    output logic                       arready,
    output sata_mon_pkg::axil_rd_rsp_t rd_rsp,
    input  logic                       rready,
    input  sata_mon_pkg::frame_stat_t  last_stat,
    input  logic                       in_frame,
    input  logic                       dword_aligned
);

    localparam int STAT_W = $bits(sata_mon_pkg::frame_stat_t);

    logic                  rvalid_r;
    logic [`SATA_DW_W-1:0] rdata_r;
    logic [1:0]            rresp_r;
    logic [`SATA_DW_W-1:0] rd_data;
    logic [1:0]            rd_resp;
    logic                  ar_hs;

    assign arready = !rvalid_r;          // one read outstanding
    assign ar_hs   = rd_req.arvalid && arready;

    always_comb begin
        rd_data = '0;
        rd_resp = `SATA_RESP_OKAY;
        case (rd_req.araddr)
            `SATA_REG_STAT: begin
                rd_data = {{(`SATA_DW_W-STAT_W){1'b0}}, last_stat};
            end
            `SATA_REG_LINK: begin
                rd_data = {{(`SATA_DW_W-2){1'b0}}, in_frame, dword_aligned};
            end
            default: begin
                rd_resp = `SATA_RESP_SLVERR;  // unmapped offset
            end
        endcase
    end

    always_ff @(posedge gtrefclk) begin
        if (!rst_n) begin
            rvalid_r <= 1'b0;
        end else if (ar_hs) begin
            rvalid_r <= 1'b1;
        end else if (rready) begin
            rvalid_r <= 1'b0;
        end
    end

    // data held until the master takes it
    always_ff @(posedge gtrefclk) begin
        if (ar_hs) begin
            rdata_r <= rd_data;
            rresp_r <= rd_resp;
        end
    end

    assign rd_rsp = '{rvalid: rvalid_r, rdata: rdata_r, rresp: rresp_r};

endmodule

// File: rtl/sata_word_assembler.sv
`timescale 1ns/1ps
`include "sata_mon_params.svh"

module sata_word_assembler (
    input  logic                      gtrefclk,
    input  logic                      rst_n,
    input  sata_mon_pkg::halfword_t   rx_hw,
    input  logic                      link_aligned,
    output sata_mon_pkg::dword_beat_t beat,
    output logic                      dword_aligned
);

    sata_mon_pkg::halfword_t prev_hw;   // low half of the pending pair
    sata_mon_pkg::dword_u    cand;
    logic [`SATA_K_DW_W-1:0] cand_k;
    logic                    hi_phase;  // rx_hw is the upper half
    logic                    align_hit;
    logic                    beat_vld;
    sata_mon_pkg::dword_u    beat_word;
    logic [`SATA_K_DW_W-1:0] beat_k;

    always_comb begin
        cand.raw = {rx_hw.data, prev_hw.data};
        cand_k   = {rx_hw.charisk, prev_hw.charisk};
    end

    // search only while the pairing is unknown
    assign align_hit = link_aligned && !dword_aligned &&
                       (cand.raw == `SATA_PRIM_ALIGN) && (cand_k == 4'b0001);

    always_ff @(posedge gtrefclk) begin
        if (!rst_n) begin
            dword_aligned <= 1'b0;
            hi_phase      <= 1'b1;
            beat_vld      <= 1'b0;
        end else begin
            if (!link_aligned) begin
                dword_aligned <= 1'b0;
            end else if (align_hit) begin
                dword_aligned <= 1'b1;
            end

            if (!dword_aligned && !align_hit) begin
                hi_phase <= 1'b1;           // every halfword may close a pair
            end else begin
                hi_phase <= !hi_phase;
            end

            beat_vld <= align_hit || (dword_aligned && hi_phase);
        end
    end

    always_ff @(posedge gtrefclk) begin
        prev_hw   <= rx_hw;
        beat_word <= cand;
        beat_k    <= cand_k;
    end

    assign beat = '{valid: beat_vld, word: beat_word, charisk: beat_k};

endmodule

// File: sata_rx_monitor.f
+incdir+rtl
rtl/sata_mon_pkg.sv
rtl/sata_word_assembler.sv
rtl/sata_prim_decoder.sv
rtl/sata_frame_monitor.sv
rtl/sata_stat_regs.sv
rtl/sata_rx_monitor.sv
verif/tb_sata_rx_monitor.sv

// File: verif/tb_sata_rx_monitor.sv
`timescale 1ns/1ps
`include "sata_mon_params.svh"

module tb_sata_rx_monitor;

    typedef struct {
        string      name;
        string      syms;      // A S E C H R W D F, one letter per dword
        bit         odd_lead;
        int         drop_at;   // symbol index where link_aligned falls, -1 for none
        logic [3:0] addr;
        logic [31:0] exp_data;
        logic [1:0] exp_resp;
    } test_t;

    localparam logic [31:0] FILL_DW = 32'hB5B5957C;  // SYNCp, decodes as other
    localparam sata_mon_pkg::halfword_t IDLE_HW = '{data: 16'hB5B5, charisk: 2'b00};
    localparam sata_mon_pkg::halfword_t ODD_HW  = '{data: 16'h1F1F, charisk: 2'b00};

    logic                       gtrefclk;
    logic                       rst_n;
    sata_mon_pkg::halfword_t    rx_hw;
    logic                       link_aligned;
    sata_mon_pkg::axil_rd_req_t rd_req;
    logic                       arready;
    sata_mon_pkg::axil_rd_rsp_t rd_rsp;
    logic                       rready;

    test_t       test_q[$];
    logic [31:0] lfsr_state = 32'h0f6d2626;
    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    sata_rx_monitor i_sata_rx_monitor (
        .gtrefclk     (gtrefclk),
        .rst_n        (rst_n),
        .rx_hw        (rx_hw),
        .link_aligned (link_aligned),
        .rd_req       (rd_req),
        .arready      (arready),
        .rd_rsp       (rd_rsp),
        .rready       (rready)
    );

    initial begin
        gtrefclk = 1'b0;
        forever #5 gtrefclk = !gtrefclk;
    end

    always @(posedge gtrefclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic add_test(input string name, input string syms, input bit odd_lead,
                            input int drop_at, input logic [3:0] addr,
                            input logic [31:0] exp_data, input logic [1:0] exp_resp);
        test_t t;
        t.name     = name;
        t.syms     = syms;
        t.odd_lead = odd_lead;
        t.drop_at  = drop_at;
        t.addr     = addr;
        t.exp_data = exp_data;
        t.exp_resp = exp_resp;
        test_q.push_back(t);
    endtask

    task automatic symbol_word(input byte c, output logic [31:0] d, output logic [3:0] k);
        k = 4'b0001;
        case (c)
            "A": d = `SATA_PRIM_ALIGN;
            "S": d = `SATA_PRIM_SOF;
            "E": d = `SATA_PRIM_EOF;
            "C": d = `SATA_PRIM_CONT;
            "H": d = `SATA_PRIM_HOLD;
            "R": d = `SATA_PRIM_HOLDA;
            "W": d = `SATA_PRIM_WTRM;
            "D": begin
                d = take_bits(32);
                k = 4'b0000;
            end
            default: d = FILL_DW;
        endcase
    endtask

    task automatic apply_reset();
        @(posedge gtrefclk);
        rst_n        <= 1'b0;
        rx_hw        <= IDLE_HW;
        link_aligned <= 1'b1;
        repeat (3) @(posedge gtrefclk);
        rst_n <= 1'b1;
    endtask

    task automatic send_dword(input logic [31:0] d, input logic [3:0] k, input bit drop);
        @(posedge gtrefclk);
        rx_hw <= '{data: d[15:0], charisk: k[1:0]};  // low half first
        if (drop) begin
            link_aligned <= 1'b0;
        end
        @(posedge gtrefclk);
        rx_hw <= '{data: d[31:16], charisk: k[3:2]};
    endtask

    task automatic check_rsp(input string name, input sata_mon_pkg::axil_rd_rsp_t exp,
                             input sata_mon_pkg::axil_rd_rsp_t act);
        if (act.rvalid !== exp.rvalid || act.rdata !== exp.rdata || act.rresp !== exp.rresp) begin
            $display("mismatch %0s rsp (valid/data/resp) expected %b/%h/%b actual %b/%h/%b",
                     name, exp.rvalid, exp.rdata, exp.rresp, act.rvalid, act.rdata, act.rresp);
            err_cnt++;
        end
    endtask

    task automatic check_stat(input string name, input sata_mon_pkg::frame_stat_t exp,
                              input sata_mon_pkg::frame_stat_t act);
        if (act !== exp) begin
            $display("mismatch %0s stat expected prims=%b count=%0d actual prims=%b count=%0d",
                     name, exp.prims, exp.count, act.prims, act.count);
            err_cnt++;
        end
    endtask

    task automatic check_link(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch %0s link expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic read_reg(input string name, input logic [3:0] addr,
                            output sata_mon_pkg::axil_rd_rsp_t rsp, output bit ok);
        sata_mon_pkg::axil_rd_rsp_t first;
        int stall;
        int wait_cnt;
        ok    = 1'b0;
        rsp   = '0;
        stall = int'(take_bits(2));  // 0 to 3 cycles of rready low
        @(posedge gtrefclk);
        rd_req <= '{arvalid: 1'b1, araddr: addr};
        wait_cnt = 0;
        @(negedge gtrefclk);
        while (!arready && wait_cnt < 16) begin
            @(negedge gtrefclk);
            wait_cnt++;
        end
        if (!arready) begin
            $display("%0s: read of offset %h was never accepted", name, addr);
            err_cnt++;
            return;
        end
        @(posedge gtrefclk);  // address handshake
        rd_req <= '0;
        wait_cnt = 0;
        @(negedge gtrefclk);
        while (!rd_rsp.rvalid && wait_cnt < 16) begin
            @(negedge gtrefclk);
            wait_cnt++;
        end
        if (!rd_rsp.rvalid) begin
            $display("%0s: read of offset %h never returned a response", name, addr);
            err_cnt++;
            return;
        end
        first = rd_rsp;
        for (int i = 0; i < stall; i++) begin
            @(negedge gtrefclk);
            check_rsp({name, " held"}, first, rd_rsp);
            if (arready) begin
                $display("%0s: arready went high while a response was pending", name);
                err_cnt++;
            end
        end
        @(posedge gtrefclk);
        rready <= 1'b1;
        @(posedge gtrefclk);  // response taken here
        rready <= 1'b0;
        @(negedge gtrefclk);
        if (!arready || rd_rsp.rvalid) begin
            $display("%0s: slave not idle after the response was taken", name);
            err_cnt++;
        end
        rsp = first;
        ok  = 1'b1;
    endtask

    task automatic run_test(input test_t t);
        sata_mon_pkg::axil_rd_rsp_t  rsp;
        sata_mon_pkg::axil_rd_rsp_t  exp_rsp;
        sata_mon_pkg::frame_stat_t   act_stat;
        logic [31:0] d;
        logic [3:0]  k;
        bit          ok;
        int          errs_before;
        errs_before = err_cnt;
        apply_reset();
        if (t.odd_lead) begin
            @(posedge gtrefclk);
            rx_hw <= ODD_HW;
        end
        for (int i = 0; i < t.syms.len(); i++) begin
            symbol_word(t.syms[i], d, k);
            send_dword(d, k, t.drop_at >= 0 && i == t.drop_at);
        end
        @(posedge gtrefclk);
        rx_hw <= IDLE_HW;
        repeat (8) @(posedge gtrefclk);
        read_reg(t.name, t.addr, rsp, ok);
        if (ok) begin
            exp_rsp = '{rvalid: 1'b1, rdata: t.exp_data, rresp: t.exp_resp};
            check_rsp(t.name, exp_rsp, rsp);
            if (t.addr == `SATA_REG_STAT) begin
                act_stat = rsp.rdata[15:0];
                check_stat(t.name, t.exp_data[15:0], act_stat);
            end else if (t.addr == `SATA_REG_LINK) begin
                check_link(t.name, t.exp_data, rsp.rdata);
            end
        end
        if (err_cnt == errs_before) begin
            $display("test %0s: ok", t.name);
            pass_cnt++;
        end else begin
            $display("test %0s: failed", t.name);
            fail_cnt++;
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        rx_hw        = IDLE_HW;
        link_aligned = 1'b0;
        rd_req       = '0;
        rready       = 1'b0;

        add_test("align_odd_lead", "AF", 1'b1, -1, `SATA_REG_LINK, 32'h1, `SATA_RESP_OKAY);
        add_test("no_align", "FFFF", 1'b0, -1, `SATA_REG_LINK, 32'h0, `SATA_RESP_OKAY);
        add_test("data_count", "ASDDDDDEDDS", 1'b0, -1, `SATA_REG_STAT, 32'h5,
                 `SATA_RESP_OKAY);
        add_test("data_count_link", "ASDDDDDEDDS", 1'b0, -1, `SATA_REG_LINK, 32'h3,
                 `SATA_RESP_OKAY);
        add_test("prim_collect", "ASDHDWCES", 1'b0, -1, `SATA_REG_STAT, 32'hD002,
                 `SATA_RESP_OKAY);
        add_test("prim_holda", "ASDRES", 1'b0, -1, `SATA_REG_STAT, 32'h2001,
                 `SATA_RESP_OKAY);
        add_test("align_loss_stat", "ASDDDFF", 1'b0, 6, `SATA_REG_STAT, 32'h3,
                 `SATA_RESP_OKAY);
        add_test("align_loss_link", "ASDDDFF", 1'b0, 6, `SATA_REG_LINK, 32'h0,
                 `SATA_RESP_OKAY);
        // runs after a test that leaves last_stat nonzero
        add_test("stat_after_reset", "F", 1'b0, -1, `SATA_REG_STAT, 32'h0, `SATA_RESP_OKAY);
        add_test("bad_offset", "AS", 1'b0, -1, 4'h8, 32'h0, `SATA_RESP_SLVERR);

        cycle_limit = test_q.size() * (2 * 16 + 8 + 20);

        foreach (test_q[i]) begin
            run_test(test_q[i]);
        end

        $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
